//--- usb_bulk_pkg.sv
package usb_bulk_pkg;

  // Widths that carry a meaning on the USB side
  typedef logic [6:0] usb_addr_t;
  typedef logic [3:0] usb_endp_t;
  typedef logic [7:0] usb_byte_t;

  // Packet identifier as {kind, group}
  typedef logic [3:0] pid_t;

  // Token group 01
  localparam pid_t PID_OUT   = 4'b0001;
  localparam pid_t PID_IN    = 4'b1001;
  // Handshake group 10
  localparam pid_t PID_ACK   = 4'b0010;
  localparam pid_t PID_NAK   = 4'b1010;
  // Data group 11
  localparam pid_t PID_DATA0 = 4'b0011;
  localparam pid_t PID_DATA1 = 4'b1011;

  typedef struct packed {
    usb_addr_t addr;
    usb_endp_t endp;
    pid_t      pid;
  } token_t;

  // keep low with last high is a zero-length packet
  typedef struct packed {
    usb_byte_t data;
    logic      keep;
    logic      last;
  } stream_beat_t;

  typedef enum logic [1:0] {
    ROUTE_NONE,
    ROUTE_IN,
    ROUTE_OUT,
    ROUTE_DROP
  } route_e;

  typedef enum logic [2:0] {
    IDLE,
    IN_TX,
    IN_WAIT_ACK,
    OUT_RX,
    OUT_DROP,
    HSK_SEND,
    DONE
  } bulk_state_e;

endpackage

//--- turnaround_timer.sv
`timescale 1ns/1ps
module turnaround_timer #(
  parameter int unsigned TURNAROUND_CYCLES = 64
) (
  input  logic clock,
  input  logic reset,
  input  logic start_i,
  input  logic stop_i,
  output logic expired_o
);

  localparam int unsigned CW = $clog2(TURNAROUND_CYCLES + 1);

  typedef logic [CW-1:0] count_t;

  // Loaded one short so that expired_o lands TURNAROUND_CYCLES after start_i
  localparam count_t LOAD = count_t'(TURNAROUND_CYCLES - 1);

  count_t count_q;
  logic   active_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      count_q   <= '0;
      active_q  <= 1'b0;
      expired_o <= 1'b0;
    end else begin
      expired_o <= 1'b0;
      if (start_i) begin
        count_q  <= LOAD;
        active_q <= 1'b1;
      end else if (stop_i) begin
        active_q <= 1'b0;
      end else if (active_q && count_q <= count_t'(1)) begin
        count_q   <= '0;
        active_q  <= 1'b0;
        expired_o <= 1'b1;
      end else if (active_q) begin
        count_q <= count_q - count_t'(1);
      end
    end
  end

endmodule

//--- data_toggle.sv
`timescale 1ns/1ps
module data_toggle (
  input  logic               clock,
  input  logic               reset,
  input  logic               config_reset_i,
  input  logic               flip_i,
  input  usb_bulk_pkg::pid_t usb_rx_pid_i,
  output usb_bulk_pkg::pid_t tx_pid_o,
  output logic               seq_match_o
);

  // Sequence bit of the bulk endpoint, 0 means DATA0
  logic seq_q;

  // A configuration event restarts the endpoint at DATA0
  always_ff @(posedge clock) begin
    if (reset || config_reset_i) begin
      seq_q <= 1'b0;
    end else if (flip_i) begin
      seq_q <= ~seq_q;
    end
  end

  assign tx_pid_o = seq_q ? usb_bulk_pkg::PID_DATA1 : usb_bulk_pkg::PID_DATA0;

  // Receive and transmit share the same expected identifier
  assign seq_match_o = usb_rx_pid_i == tx_pid_o;

endmodule

//--- bulk_stream_router.sv
`timescale 1ns/1ps
module bulk_stream_router (
  input  usb_bulk_pkg::route_e       route_i,
  input  logic                       usb_rx_valid_i,
  input  usb_bulk_pkg::stream_beat_t usb_rx_i,
  output logic                       usb_rx_ready_o,
  output logic                       usb_tx_valid_o,
  output usb_bulk_pkg::stream_beat_t usb_tx_o,
  input  logic                       usb_tx_ready_i,
  input  logic                       blk_in_valid_i,
  input  usb_bulk_pkg::stream_beat_t blk_in_i,
  output logic                       blk_in_ready_o,
  output logic                       blk_out_valid_o,
  output usb_bulk_pkg::stream_beat_t blk_out_o,
  input  logic                       blk_out_ready_i,
  output logic                       rx_done_o
);

  logic rx_fire;

  // Payload passes straight through, only the handshakes are steered
  assign usb_tx_o  = blk_in_i;
  assign blk_out_o = usb_rx_i;

  always_comb begin
    usb_rx_ready_o  = 1'b0;
    usb_tx_valid_o  = 1'b0;
    blk_in_ready_o  = 1'b0;
    blk_out_valid_o = 1'b0;
    case (route_i)
      usb_bulk_pkg::ROUTE_IN: begin
        usb_tx_valid_o = blk_in_valid_i;
        blk_in_ready_o = usb_tx_ready_i;
      end
      usb_bulk_pkg::ROUTE_OUT: begin
        blk_out_valid_o = usb_rx_valid_i;
        usb_rx_ready_o  = blk_out_ready_i;
      end
      usb_bulk_pkg::ROUTE_DROP: begin
        // Sink the packet so the decoder can finish it
        usb_rx_ready_o = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // Decoder ready is only high in OUT and DROP
  assign rx_fire   = usb_rx_valid_i && usb_rx_ready_o;
  assign rx_done_o = rx_fire && usb_rx_i.last;

endmodule

//--- usb_bulk_fsm.sv
`timescale 1ns/1ps
module usb_bulk_fsm #(
  parameter int unsigned BULK_ENDPOINT = 1
) (
  input  logic                    clock,
  input  logic                    reset,
  input  usb_bulk_pkg::usb_addr_t usb_addr_i,
  input  logic                    tok_recv_i,
  input  usb_bulk_pkg::token_t    tok_i,
  input  logic                    hsk_recv_i,
  input  usb_bulk_pkg::pid_t      hsk_pid_i,
  input  logic                    hsk_sent_i,
  input  logic                    usb_sent_i,
  input  logic                    blk_in_avail_i,
  input  logic                    blk_out_space_i,
  input  logic                    rx_done_i,
  input  logic                    seq_match_i,
  input  logic                    expired_i,
  output usb_bulk_pkg::route_e    route_o,
  output logic                    timer_start_o,
  output logic                    timer_stop_o,
  output logic                    toggle_flip_o,
  output logic                    hsk_send_o,
  output usb_bulk_pkg::pid_t      hsk_pid_o,
  output logic                    blk_fetch_o,
  output logic                    blk_store_o,
  output logic                    timeout_o
);

  usb_bulk_pkg::bulk_state_e state_q;
  logic tok_ours;
  logic tok_in;
  logic tok_out;
  logic host_ack;
  logic in_idle;
  logic out_rx;

  // Token for this device address and the bulk endpoint
  assign tok_ours = tok_recv_i && tok_i.addr == usb_addr_i &&
                    tok_i.endp == usb_bulk_pkg::usb_endp_t'(BULK_ENDPOINT);
  assign tok_in   = tok_ours && tok_i.pid == usb_bulk_pkg::PID_IN;
  assign tok_out  = tok_ours && tok_i.pid == usb_bulk_pkg::PID_OUT;
  assign host_ack = hsk_recv_i && hsk_pid_i == usb_bulk_pkg::PID_ACK;

  assign in_idle = state_q == usb_bulk_pkg::IDLE;
  assign out_rx  = state_q == usb_bulk_pkg::OUT_RX || state_q == usb_bulk_pkg::OUT_DROP;

  always_comb begin
    case (state_q)
      usb_bulk_pkg::IN_TX:    route_o = usb_bulk_pkg::ROUTE_IN;
      usb_bulk_pkg::OUT_RX:   route_o = usb_bulk_pkg::ROUTE_OUT;
      usb_bulk_pkg::OUT_DROP: route_o = usb_bulk_pkg::ROUTE_DROP;
      default:                route_o = usb_bulk_pkg::ROUTE_NONE;
    endcase
  end

  // Turnaround runs from the OUT token, or from the end of our IN data packet
  assign timer_start_o = (in_idle && tok_out) ||
                         (state_q == usb_bulk_pkg::IN_TX && usb_sent_i);
  assign timer_stop_o  = (state_q == usb_bulk_pkg::IN_WAIT_ACK && hsk_recv_i) ||
                         (out_rx && rx_done_i);

  // A repeated OUT packet is ACKed but leaves the sequence bit alone
  assign toggle_flip_o = (state_q == usb_bulk_pkg::IN_WAIT_ACK && host_ack) ||
                         (state_q == usb_bulk_pkg::OUT_RX && rx_done_i && seq_match_i);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q     <= usb_bulk_pkg::IDLE;
      hsk_send_o  <= 1'b0;
      blk_fetch_o <= 1'b0;
      blk_store_o <= 1'b0;
      timeout_o   <= 1'b0;
    end else begin
      blk_fetch_o <= 1'b0;
      blk_store_o <= 1'b0;
      timeout_o   <= 1'b0;
      case (state_q)
        usb_bulk_pkg::IDLE: begin
          if (tok_in && blk_in_avail_i) begin
            state_q     <= usb_bulk_pkg::IN_TX;
            blk_fetch_o <= 1'b1;
          end else if (tok_in) begin
            state_q    <= usb_bulk_pkg::HSK_SEND;
            hsk_send_o <= 1'b1;
          end else if (tok_out) begin
            state_q     <= blk_out_space_i ? usb_bulk_pkg::OUT_RX : usb_bulk_pkg::OUT_DROP;
            blk_store_o <= blk_out_space_i;
          end
        end
        usb_bulk_pkg::IN_TX: begin
          if (usb_sent_i) begin
            state_q <= usb_bulk_pkg::IN_WAIT_ACK;
          end
        end
        usb_bulk_pkg::IN_WAIT_ACK: begin
          if (hsk_recv_i) begin
            state_q <= usb_bulk_pkg::DONE;
          end else if (expired_i) begin
            state_q   <= usb_bulk_pkg::IDLE;
            timeout_o <= 1'b1;
          end
        end
        usb_bulk_pkg::OUT_RX, usb_bulk_pkg::OUT_DROP: begin
          if (rx_done_i) begin
            state_q    <= usb_bulk_pkg::HSK_SEND;
            hsk_send_o <= 1'b1;
          end else if (expired_i) begin
            state_q   <= usb_bulk_pkg::IDLE;
            timeout_o <= 1'b1;
          end
        end
        usb_bulk_pkg::HSK_SEND: begin
          if (hsk_sent_i) begin
            state_q    <= usb_bulk_pkg::DONE;
            hsk_send_o <= 1'b0;
          end
        end
        default: begin
          state_q <= usb_bulk_pkg::IDLE;
        end
      endcase
    end
  end

  // Handshake code is loaded together with the rise of hsk_send_o
  always_ff @(posedge clock) begin
    if (in_idle && tok_in && !blk_in_avail_i) begin
      hsk_pid_o <= usb_bulk_pkg::PID_NAK;
    end else if (state_q == usb_bulk_pkg::OUT_RX && rx_done_i) begin
      hsk_pid_o <= usb_bulk_pkg::PID_ACK;
    end else if (state_q == usb_bulk_pkg::OUT_DROP && rx_done_i) begin
      hsk_pid_o <= usb_bulk_pkg::PID_NAK;
    end
  end

endmodule

//--- usb_bulk_transactor.sv
`timescale 1ns/1ps
module usb_bulk_transactor #(
  parameter int unsigned BULK_ENDPOINT     = 1,
  parameter int unsigned TURNAROUND_CYCLES = 64
) (
  input  logic                       clock,
  input  logic                       reset,
  input  usb_bulk_pkg::usb_addr_t    usb_addr_i,
  input  logic                       config_reset_i,
  input  logic                       tok_recv_i,
  input  usb_bulk_pkg::token_t       tok_i,
  input  logic                       hsk_recv_i,
  input  usb_bulk_pkg::pid_t         hsk_pid_i,
  input  logic                       hsk_sent_i,
  input  logic                       usb_sent_i,
  input  logic                       usb_rx_valid_i,
  input  usb_bulk_pkg::stream_beat_t usb_rx_i,
  input  usb_bulk_pkg::pid_t         usb_rx_pid_i,
  input  logic                       usb_tx_ready_i,
  input  logic                       blk_in_avail_i,
  input  logic                       blk_out_space_i,
  input  logic                       blk_in_valid_i,
  input  usb_bulk_pkg::stream_beat_t blk_in_i,
  input  logic                       blk_out_ready_i,
  output logic                       hsk_send_o,
  output usb_bulk_pkg::pid_t         hsk_pid_o,
  output logic                       usb_rx_ready_o,
  output logic                       usb_tx_valid_o,
  output usb_bulk_pkg::stream_beat_t usb_tx_o,
  output usb_bulk_pkg::pid_t         usb_tx_pid_o,
  output logic                       blk_in_ready_o,
  output logic                       blk_out_valid_o,
  output usb_bulk_pkg::stream_beat_t blk_out_o,
  output logic                       blk_fetch_o,
  output logic                       blk_store_o,
  output logic                       timeout_o
);

  usb_bulk_pkg::route_e route;
  logic rx_done;
  logic timer_start;
  logic timer_stop;
  logic expired;
  logic toggle_flip;
  logic seq_match;

  usb_bulk_fsm #(
    .BULK_ENDPOINT(BULK_ENDPOINT)
  ) usb_bulk_fsm_i (
    .clock          (clock),
    .reset          (reset),
    .usb_addr_i     (usb_addr_i),
    .tok_recv_i     (tok_recv_i),
    .tok_i          (tok_i),
    .hsk_recv_i     (hsk_recv_i),
    .hsk_pid_i      (hsk_pid_i),
    .hsk_sent_i     (hsk_sent_i),
    .usb_sent_i     (usb_sent_i),
    .blk_in_avail_i (blk_in_avail_i),
    .blk_out_space_i(blk_out_space_i),
    .rx_done_i      (rx_done),
    .seq_match_i    (seq_match),
    .expired_i      (expired),
    .route_o        (route),
    .timer_start_o  (timer_start),
    .timer_stop_o   (timer_stop),
    .toggle_flip_o  (toggle_flip),
    .hsk_send_o     (hsk_send_o),
    .hsk_pid_o      (hsk_pid_o),
    .blk_fetch_o    (blk_fetch_o),
    .blk_store_o    (blk_store_o),
    .timeout_o      (timeout_o)
  );

  turnaround_timer #(
    .TURNAROUND_CYCLES(TURNAROUND_CYCLES)
  ) turnaround_timer_i (
    .clock    (clock),
    .reset    (reset),
    .start_i  (timer_start),
    .stop_i   (timer_stop),
    .expired_o(expired)
  );

  data_toggle data_toggle_i (
    .clock         (clock),
    .reset         (reset),
    .config_reset_i(config_reset_i),
    .flip_i        (toggle_flip),
    .usb_rx_pid_i  (usb_rx_pid_i),
    .tx_pid_o      (usb_tx_pid_o),
    .seq_match_o   (seq_match)
  );

  bulk_stream_router bulk_stream_router_i (
    .route_i        (route),
    .usb_rx_valid_i (usb_rx_valid_i),
    .usb_rx_i       (usb_rx_i),
    .usb_rx_ready_o (usb_rx_ready_o),
    .usb_tx_valid_o (usb_tx_valid_o),
    .usb_tx_o       (usb_tx_o),
    .usb_tx_ready_i (usb_tx_ready_i),
    .blk_in_valid_i (blk_in_valid_i),
    .blk_in_i       (blk_in_i),
    .blk_in_ready_o (blk_in_ready_o),
    .blk_out_valid_o(blk_out_valid_o),
    .blk_out_o      (blk_out_o),
    .blk_out_ready_i(blk_out_ready_i),
    .rx_done_o      (rx_done)
  );

endmodule

//--- usb_bulk_transactor_props.sv
`timescale 1ns/1ps
module usb_bulk_transactor_props (
  input logic               clock,
  input logic               reset,
  input logic               fetch_i,
  input logic               store_i,
  input logic               hsk_send_i,
  input logic               hsk_sent_i,
  input usb_bulk_pkg::pid_t send_pid_i
);

  // Failures seen so far, the testbench looks at this at the end
  int unsigned assert_failures = 0;

  // IN and OUT replies never overlap
  fetch_store_apart: assert property (@(posedge clock) disable iff (reset)
    !(fetch_i && store_i))
  else begin
    assert_failures++;
    $error("blk_fetch_o and blk_store_o are high together");
  end

  hsk_send_held: assert property (@(posedge clock) disable iff (reset)
    hsk_send_i && !hsk_sent_i |=> hsk_send_i)
  else begin
    assert_failures++;
    $error("hsk_send_o dropped before hsk_sent_i");
  end

  hsk_pid_legal: assert property (@(posedge clock) disable iff (reset)
    hsk_send_i |-> (send_pid_i == usb_bulk_pkg::PID_ACK || send_pid_i == usb_bulk_pkg::PID_NAK))
  else begin
    assert_failures++;
    $error("hsk_pid_o is neither ACK nor NAK while hsk_send_o is high");
  end

endmodule

bind usb_bulk_transactor usb_bulk_transactor_props props_i (
  .clock     (clock),
  .reset     (reset),
  .fetch_i   (blk_fetch_o),
  .store_i   (blk_store_o),
  .hsk_send_i(hsk_send_o),
  .hsk_sent_i(hsk_sent_i),
  .send_pid_i(hsk_pid_o)
);

//--- usb_bulk_transactor_tb.sv
`timescale 1ns/1ps
module usb_bulk_transactor_tb;

  localparam int unsigned BULK_ENDPOINT     = 1;
  localparam int unsigned TURNAROUND_CYCLES = 64;
  // The full test sequence needs under 2000 cycles
  localparam int unsigned CYCLE_LIMIT = 20000;

  localparam usb_bulk_pkg::usb_addr_t DEV_ADDR   = 7'h2a;
  localparam usb_bulk_pkg::usb_addr_t OTHER_ADDR = 7'h2b;
  localparam usb_bulk_pkg::usb_endp_t BULK_ENDP  = usb_bulk_pkg::usb_endp_t'(BULK_ENDPOINT);
  localparam usb_bulk_pkg::usb_endp_t OTHER_ENDP = 4'd2;

  logic clock = 1'b0;
  logic reset;
  usb_bulk_pkg::usb_addr_t    usb_addr_i;
  logic                       config_reset_i, tok_recv_i, hsk_recv_i, hsk_sent_i, usb_sent_i;
  usb_bulk_pkg::token_t       tok_i;
  usb_bulk_pkg::pid_t         hsk_pid_i, usb_rx_pid_i;
  logic                       usb_rx_valid_i, usb_tx_ready_i, blk_in_valid_i, blk_out_ready_i;
  logic                       blk_in_avail_i, blk_out_space_i;
  usb_bulk_pkg::stream_beat_t usb_rx_i, blk_in_i;
  logic                       hsk_send_o, usb_rx_ready_o, usb_tx_valid_o, blk_in_ready_o;
  logic                       blk_out_valid_o, blk_fetch_o, blk_store_o, timeout_o;
  usb_bulk_pkg::pid_t         hsk_pid_o, usb_tx_pid_o;
  usb_bulk_pkg::stream_beat_t usb_tx_o, blk_out_o;

  // Expected sequence bit of the endpoint, 0 means DATA0
  logic seq_model;
  int unsigned cycle_count = 0;
  usb_bulk_pkg::stream_beat_t payload[$];

  usb_bulk_transactor #(
    .BULK_ENDPOINT    (BULK_ENDPOINT),
    .TURNAROUND_CYCLES(TURNAROUND_CYCLES)
  ) usb_bulk_transactor_i (.*);

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      fail_run("the run passed its cycle limit before all tests finished");
    end
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_beat(input usb_bulk_pkg::stream_beat_t got,
                            input usb_bulk_pkg::stream_beat_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("error %0t: %s got data %h keep %b last %b, expected %h %b %b",
                         $time, what, got.data, got.keep, got.last,
                         exp.data, exp.keep, exp.last));
    end
  endtask

  task automatic check_pid(input usb_bulk_pkg::pid_t got, input usb_bulk_pkg::pid_t exp,
                           input string what);
    if (got !== exp) begin
      fail_run($sformatf("error %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("error %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  // DATA0 or DATA1 for a sequence bit
  function automatic usb_bulk_pkg::pid_t data_pid(input logic seq);
    return seq ? usb_bulk_pkg::PID_DATA1 : usb_bulk_pkg::PID_DATA0;
  endfunction

  task automatic make_payload(input int n);
    payload.delete();
    for (int k = 0; k < n; k++) begin
      payload.push_back('{data: usb_bulk_pkg::usb_byte_t'($urandom), keep: 1'b1,
                          last: k == n - 1});
    end
  endtask

  // Returns at the negedge after the DUT sampled the token
  task automatic send_token(input usb_bulk_pkg::pid_t pid, input usb_bulk_pkg::usb_addr_t addr,
                            input usb_bulk_pkg::usb_endp_t endp);
    @(posedge clock);
    tok_recv_i <= 1'b1;
    tok_i      <= '{addr: addr, endp: endp, pid: pid};
    @(posedge clock);
    tok_recv_i <= 1'b0;
    @(negedge clock);
  endtask

  task automatic expect_handshake(input usb_bulk_pkg::pid_t exp_pid);
    check_flag(hsk_send_o, 1'b1, "hsk_send_o");
    check_pid(hsk_pid_o, exp_pid, "hsk_pid_o");
    @(posedge clock);
    hsk_sent_i <= 1'b1;
    @(posedge clock);
    hsk_sent_i <= 1'b0;
    @(negedge clock);
    check_flag(hsk_send_o, 1'b0, "hsk_send_o after hsk_sent_i");
    // DONE goes back to IDLE on this edge
    @(posedge clock);
  endtask

  // Decoder side of an OUT packet, the testbench is also the buffer sink
  task automatic drive_out_data(input usb_bulk_pkg::pid_t pid, input logic to_sink);
    int idx;
    idx = 0;
    while (idx < payload.size()) begin
      @(posedge clock);
      usb_rx_valid_i  <= 1'b1;
      usb_rx_i        <= payload[idx];
      usb_rx_pid_i    <= pid;
      blk_out_ready_i <= ($urandom % 4) != 0;
      @(negedge clock);
      check_flag(blk_out_valid_o, to_sink, "blk_out_valid_o");
      check_flag(usb_rx_ready_o, to_sink ? blk_out_ready_i : 1'b1, "usb_rx_ready_o");
      check_flag(blk_store_o, 1'b0, "blk_store_o during data");
      if (to_sink && blk_out_ready_i) begin
        check_beat(blk_out_o, payload[idx], "buffer sink beat");
      end
      if (usb_rx_ready_o) begin
        idx++;
      end
    end
    @(posedge clock);
    usb_rx_valid_i  <= 1'b0;
    blk_out_ready_i <= 1'b0;
    @(negedge clock);
  endtask

  task automatic out_transaction(input int n, input usb_bulk_pkg::pid_t pid, input logic space);
    make_payload(n);
    @(posedge clock);
    blk_out_space_i <= space;
    send_token(usb_bulk_pkg::PID_OUT, DEV_ADDR, BULK_ENDP);
    check_flag(blk_store_o, space, "blk_store_o after OUT token");
    check_flag(blk_fetch_o, 1'b0, "blk_fetch_o after OUT token");
    drive_out_data(pid, space);
    if (space) begin
      expect_handshake(usb_bulk_pkg::PID_ACK);
      if (pid == data_pid(seq_model)) begin
        seq_model = !seq_model;
      end
    end else begin
      expect_handshake(usb_bulk_pkg::PID_NAK);
    end
  endtask

  // Buffer source and encoder side of an IN packet
  task automatic in_transaction(input int n, input logic host_ack);
    int seen;
    make_payload(n);
    @(posedge clock);
    blk_in_avail_i <= 1'b1;
    send_token(usb_bulk_pkg::PID_IN, DEV_ADDR, BULK_ENDP);
    check_flag(blk_fetch_o, 1'b1, "blk_fetch_o after IN token");
    seen = 0;
    while (seen < n) begin
      @(posedge clock);
      blk_in_valid_i <= 1'b1;
      blk_in_i       <= payload[seen];
      usb_tx_ready_i <= ($urandom % 4) != 0;
      @(negedge clock);
      check_flag(hsk_send_o, 1'b0, "hsk_send_o during IN data");
      check_flag(blk_fetch_o, 1'b0, "blk_fetch_o during IN data");
      check_flag(usb_tx_valid_o, 1'b1, "usb_tx_valid_o");
      check_flag(blk_in_ready_o, usb_tx_ready_i, "blk_in_ready_o");
      check_pid(usb_tx_pid_o, data_pid(seq_model), "usb_tx_pid_o");
      if (usb_tx_ready_i) begin
        check_beat(usb_tx_o, payload[seen], "encoder beat");
        seen++;
      end
    end
    @(posedge clock);
    blk_in_valid_i <= 1'b0;
    usb_tx_ready_i <= 1'b0;
    usb_sent_i     <= 1'b1;
    @(posedge clock);
    usb_sent_i <= 1'b0;
    if (host_ack) begin
      @(posedge clock);
      hsk_recv_i <= 1'b1;
      hsk_pid_i  <= usb_bulk_pkg::PID_ACK;
      @(posedge clock);
      hsk_recv_i <= 1'b0;
      seq_model = !seq_model;
      @(negedge clock);
      check_flag(hsk_send_o, 1'b0, "hsk_send_o after host ACK");
    end
  endtask

  task automatic wait_for_timeout();
    int unsigned waited;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
      if (waited > TURNAROUND_CYCLES + 8) begin
        fail_run("timeout_o never pulsed after the IN packet went unanswered");
      end
    end while (!timeout_o);
    if (waited < TURNAROUND_CYCLES) begin
      fail_run($sformatf("error %0t: timeout_o came after only %0d cycles", $time, waited));
    end
    @(negedge clock);
    check_flag(timeout_o, 1'b0, "timeout_o one cycle after its pulse");
  endtask

  // Nothing may move for a token that is not ours
  task automatic check_quiet();
    repeat (4) begin
      check_flag(blk_fetch_o, 1'b0, "blk_fetch_o on foreign token");
      check_flag(blk_store_o, 1'b0, "blk_store_o on foreign token");
      check_flag(hsk_send_o, 1'b0, "hsk_send_o on foreign token");
      check_flag(usb_tx_valid_o, 1'b0, "usb_tx_valid_o on foreign token");
      check_flag(blk_out_valid_o, 1'b0, "blk_out_valid_o on foreign token");
      check_flag(usb_rx_ready_o, 1'b0, "usb_rx_ready_o on foreign token");
      check_flag(blk_in_ready_o, 1'b0, "blk_in_ready_o on foreign token");
      @(negedge clock);
    end
  endtask

  task automatic test_toggle_sequence();
    out_transaction(4, usb_bulk_pkg::PID_DATA0, 1'b1);
    check_pid(usb_tx_pid_o, usb_bulk_pkg::PID_DATA1, "toggle after first OUT");
    // Host retry of the same packet
    out_transaction(4, usb_bulk_pkg::PID_DATA0, 1'b1);
    check_pid(usb_tx_pid_o, usb_bulk_pkg::PID_DATA1, "toggle after repeated OUT");
    in_transaction(3, 1'b1);
    check_pid(usb_tx_pid_o, usb_bulk_pkg::PID_DATA0, "toggle after acked IN");
    in_transaction(3, 1'b1);
  endtask

  task automatic test_out_transfer();
    out_transaction(16, data_pid(seq_model), 1'b1);
  endtask

  task automatic test_in_transfer();
    in_transaction(16, 1'b1);
  endtask

  task automatic test_nak_replies();
    @(posedge clock);
    blk_in_avail_i <= 1'b0;
    send_token(usb_bulk_pkg::PID_IN, DEV_ADDR, BULK_ENDP);
    check_flag(blk_fetch_o, 1'b0, "blk_fetch_o on IN without data");
    expect_handshake(usb_bulk_pkg::PID_NAK);
    out_transaction(8, data_pid(seq_model), 1'b0);
    check_pid(usb_tx_pid_o, data_pid(seq_model), "toggle after NAK replies");
  endtask

  task automatic test_timeout();
    in_transaction(6, 1'b0);
    wait_for_timeout();
    check_pid(usb_tx_pid_o, data_pid(seq_model), "toggle after timeout");
    in_transaction(6, 1'b1);
  endtask

  task automatic test_config_and_address();
    if (!seq_model) begin
      in_transaction(2, 1'b1);
    end
    check_pid(usb_tx_pid_o, usb_bulk_pkg::PID_DATA1, "toggle before config_reset_i");
    @(posedge clock);
    config_reset_i <= 1'b1;
    @(posedge clock);
    config_reset_i <= 1'b0;
    seq_model = 1'b0;
    @(negedge clock);
    check_pid(usb_tx_pid_o, usb_bulk_pkg::PID_DATA0, "toggle after config_reset_i");
    // Offer traffic on every side while foreign tokens arrive
    @(posedge clock);
    blk_in_avail_i  <= 1'b1;
    blk_out_space_i <= 1'b1;
    blk_in_valid_i  <= 1'b1;
    usb_rx_valid_i  <= 1'b1;
    usb_rx_i        <= '{data: 8'h5a, keep: 1'b1, last: 1'b1};
    usb_tx_ready_i  <= 1'b1;
    blk_out_ready_i <= 1'b1;
    send_token(usb_bulk_pkg::PID_IN, OTHER_ADDR, BULK_ENDP);
    check_quiet();
    send_token(usb_bulk_pkg::PID_OUT, DEV_ADDR, OTHER_ENDP);
    check_quiet();
    @(posedge clock);
    blk_in_valid_i  <= 1'b0;
    usb_rx_valid_i  <= 1'b0;
    usb_tx_ready_i  <= 1'b0;
    blk_out_ready_i <= 1'b0;
    in_transaction(4, 1'b1);
  endtask

  initial begin
    void'($urandom(32'hd6b5_2d0c));
    reset           <= 1'b1;
    usb_addr_i      <= DEV_ADDR;
    config_reset_i  <= 1'b0;
    tok_recv_i      <= 1'b0;
    tok_i           <= '0;
    hsk_recv_i      <= 1'b0;
    hsk_pid_i       <= '0;
    hsk_sent_i      <= 1'b0;
    usb_sent_i      <= 1'b0;
    usb_rx_valid_i  <= 1'b0;
    usb_rx_i        <= '0;
    usb_rx_pid_i    <= '0;
    usb_tx_ready_i  <= 1'b0;
    blk_in_avail_i  <= 1'b0;
    blk_out_space_i <= 1'b0;
    blk_in_valid_i  <= 1'b0;
    blk_in_i        <= '0;
    blk_out_ready_i <= 1'b0;
    seq_model = 1'b0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_flag(hsk_send_o, 1'b0, "hsk_send_o after reset");
    check_flag(blk_fetch_o, 1'b0, "blk_fetch_o after reset");
    check_flag(blk_store_o, 1'b0, "blk_store_o after reset");
    check_flag(usb_tx_valid_o, 1'b0, "usb_tx_valid_o after reset");
    check_flag(blk_out_valid_o, 1'b0, "blk_out_valid_o after reset");
    check_flag(timeout_o, 1'b0, "timeout_o after reset");
    check_pid(usb_tx_pid_o, usb_bulk_pkg::PID_DATA0, "toggle after reset");
    test_toggle_sequence();
    test_out_transfer();
    test_in_transfer();
    test_nak_replies();
    test_timeout();
    test_config_and_address();
    if (usb_bulk_transactor_i.props_i.assert_failures == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      fail_run("a bound assertion on the handshake rules failed during the run");
    end
  end

endmodule

//--- usb_bulk_transactor.f
usb_bulk_pkg.sv
turnaround_timer.sv
data_toggle.sv
bulk_stream_router.sv
usb_bulk_fsm.sv
usb_bulk_transactor.sv
usb_bulk_transactor_props.sv
usb_bulk_transactor_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= usb_bulk_transactor_tb
FILELIST  ?= usb_bulk_transactor.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
